/* include/dot_defs.svh */
// Dot-product engine parameters
`ifndef DOT_DEFS_SVH
`define DOT_DEFS_SVH

// --------------------
// Datapath sizing
// --------------------

// Elements in each of the a and b vectors
`define DOT_VEC_LEN 32

// Width of one signed element
`define DOT_ELEM_W 8

// Accumulator start value and final result width
`define DOT_ACC_W 16

// Result FIFO entries, which is also the credit limit
`define DOT_Q_DEPTH 4

// Cycles from job_valid to sum_valid
`define DOT_LATENCY 5

// --------------------
// APB register map
// --------------------

`define DOT_APB_AW 12
`define DOT_APB_DW 32

// Register byte offsets
// Each vector block spans eight words
`define DOT_REG_A      12'h000
`define DOT_REG_B      12'h020
`define DOT_REG_ACC    12'h040
`define DOT_REG_CTRL   12'h044
`define DOT_REG_STATUS 12'h048
`define DOT_REG_RESULT 12'h04C

`endif

/* src/dot_pkg.sv */
// Dot-product engine types
`default_nettype none

`include "dot_defs.svh"

package dot_pkg;

   // --------------------
   // Arithmetic widths
   // --------------------

   typedef logic signed [`DOT_ELEM_W-1:0] elem_t;
   typedef logic signed [2*`DOT_ELEM_W-1:0] prod_t;
   // Sixteen products need four guard bits on top of one product
   typedef logic signed [2*`DOT_ELEM_W+3:0] half_sum_t;
   // One more bit covers the sum of the two halves
   typedef logic signed [2*`DOT_ELEM_W+4:0] dot_sum_t;
   typedef logic signed [`DOT_ACC_W-1:0] acc_t;
   typedef logic signed [`DOT_ACC_W+6:0] wide_sum_t;

   // Element i sits in byte i of the vector
   typedef elem_t [`DOT_VEC_LEN-1:0] vec_t;

   // --------------------
   // Bundles
   // --------------------

   typedef struct packed {
      logic [`DOT_APB_AW-1:0] paddr;
      logic                   psel;
      logic                   penable;
      logic                   pwrite;
      logic [`DOT_APB_DW-1:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [`DOT_APB_DW-1:0] prdata;
      logic                   pready;
      logic                   pslverr;
   } apb_rsp_t;

   // One complete job as handed to the datapath
   typedef struct packed {
      vec_t a;
      vec_t b;
      acc_t acc;
   } dot_job_t;

   typedef struct packed {
      acc_t value;
      logic saturated;
   } result_t;

endpackage

`default_nettype wire

/* src/dot16_tree.sv */
// Sixteen-element multiply and add tree
`timescale 1ns/1ps
`default_nettype none

`include "dot_defs.svh"

module dot16_tree (
   input  logic                                   clk,
   input  logic                                   rst,
   input  dot_pkg::elem_t [`DOT_VEC_LEN/2-1:0]   a,
   input  dot_pkg::elem_t [`DOT_VEC_LEN/2-1:0]   b,
   input  logic                                   in_valid,
   output dot_pkg::half_sum_t                     sum,
   output logic                                   out_valid
);

   import dot_pkg::*;

   // Number of element pairs handled here
   localparam int N = `DOT_VEC_LEN / 2;
   // The first tree level folds groups of four products
   localparam int GROUPS = N / 4;

   prod_t      prod_q [N];
   half_sum_t  part_q [GROUPS];
   half_sum_t  tree_total;
   // Valid bit for the product, level one and level two stages
   logic [2:0] vld_q;

   // --------------------
   // Product stage
   // --------------------

   // Both operands are signed, so the product is signed as well
   always_ff @(posedge clk) begin
      for (int i = 0; i < N; i++) begin
         prod_q[i] <= a[i] * b[i];
      end
   end

   // --------------------
   // Adder tree
   // --------------------

   // Level one turns sixteen products into four partial sums
   // The products are sign-extended by the wider assignment context
   always_ff @(posedge clk) begin
      for (int g = 0; g < GROUPS; g++) begin
         part_q[g] <= prod_q[4*g] + prod_q[4*g+1] + prod_q[4*g+2] + prod_q[4*g+3];
      end
   end

   // Level two adds the partial sums
   always_comb begin
      tree_total = '0;
      for (int g = 0; g < GROUPS; g++) begin
         tree_total += part_q[g];
      end
   end

   always_ff @(posedge clk) begin
      sum <= tree_total;
   end

   // The valid bit walks beside the data, no stage ever stalls
   always_ff @(posedge clk) begin
      if (rst) begin
         vld_q <= '0;
      end else begin
         vld_q <= {vld_q[1:0], in_valid};
      end
   end

   assign out_valid = vld_q[2];

   // Products, level one and level two each take one cycle
   a_tree_latency : assert property (@(posedge clk) disable iff (rst)
      in_valid |-> ##3 out_valid);

endmodule

`default_nettype wire

/* src/dot32_acc.sv */
// Thirty-two element dot product with accumulate
`timescale 1ns/1ps
`default_nettype none

`include "dot_defs.svh"

module dot32_acc (
   input  logic                clk,
   input  logic                rst,
   input  dot_pkg::dot_job_t   job,
   input  logic                job_valid,
   output dot_pkg::wide_sum_t  sum,
   output logic                sum_valid
);

   import dot_pkg::*;

   localparam int HALF = `DOT_VEC_LEN / 2;
   // The input register and the final add are the two stages outside the trees
   localparam int ACC_DLY = `DOT_LATENCY - 2;

   dot_job_t  job_q;
   logic      job_q_valid;
   half_sum_t lo_sum;
   half_sum_t hi_sum;
   logic      lo_valid;
   logic      hi_valid;
   dot_sum_t  dot_total;
   acc_t      acc_dly [ACC_DLY];

   // --------------------
   // Input register
   // --------------------

   // The job is captured once so the host may rewrite the registers afterwards
   always_ff @(posedge clk) begin
      if (job_valid) begin
         job_q <= job;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         job_q_valid <= 1'b0;
      end else begin
         job_q_valid <= job_valid;
      end
   end

   // --------------------
   // Two half trees
   // --------------------

   // Elements 0 to 15 go to the lower tree
   dot16_tree lo_tree_i (
      .clk       (clk),
      .rst       (rst),
      .a         (job_q.a[HALF-1:0]),
      .b         (job_q.b[HALF-1:0]),
      .in_valid  (job_q_valid),
      .sum       (lo_sum),
      .out_valid (lo_valid)
   );

   // Elements 16 to 31 go to the upper tree
   dot16_tree hi_tree_i (
      .clk       (clk),
      .rst       (rst),
      .a         (job_q.a[2*HALF-1:HALF]),
      .b         (job_q.b[2*HALF-1:HALF]),
      .in_valid  (job_q_valid),
      .sum       (hi_sum),
      .out_valid (hi_valid)
   );

   // Accumulator start value follows the trees through a matching delay line
   always_ff @(posedge clk) begin
      acc_dly[0] <= job_q.acc;
      for (int i = 1; i < ACC_DLY; i++) begin
         acc_dly[i] <= acc_dly[i-1];
      end
   end

   // --------------------
   // Final add
   // --------------------

   // Signed operands, so the wider result context sign-extends both halves
   assign dot_total = lo_sum + hi_sum;

   always_ff @(posedge clk) begin
      sum <= dot_total + acc_dly[ACC_DLY-1];
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         sum_valid <= 1'b0;
      end else begin
         sum_valid <= lo_valid;
      end
   end

   // Both trees see the same valid input and must stay in lock step
   a_trees_aligned : assert property (@(posedge clk) disable iff (rst)
      lo_valid == hi_valid);

endmodule

`default_nettype wire

/* src/apb_vector_regs.sv */
// APB vector register block
`timescale 1ns/1ps
`default_nettype none

`include "dot_defs.svh"

module apb_vector_regs (
   input  logic               clk,
   input  logic               rst,
   input  dot_pkg::apb_req_t  apb_req,
   output dot_pkg::apb_rsp_t  apb_rsp,
   output dot_pkg::dot_job_t  job,
   output logic               job_valid,
   input  dot_pkg::result_t   head,
   input  logic [2:0]         count,
   input  logic               sat_sticky,
   input  logic               credit_ok,
   output logic               pop,
   output logic               clear_sat
);

   import dot_pkg::*;

   // A vector block covers one byte per element
   localparam int BLK_SH = $clog2(`DOT_VEC_LEN);

   vec_t                   a_reg;
   vec_t                   b_reg;
   acc_t                   acc_reg;
   logic                   access;
   logic                   wr_acc;
   logic                   rd_acc;
   logic                   aligned;
   logic                   a_hit;
   logic                   b_hit;
   logic                   acc_hit;
   logic                   ctrl_hit;
   logic                   stat_hit;
   logic                   res_hit;
   logic                   mapped;
   logic [BLK_SH-3:0]      word_idx;
   logic                   start_req;
   logic                   start_ok;
   logic                   err;
   logic [`DOT_APB_DW-1:0] rd_word;

   // --------------------
   // Address decode
   // --------------------

   // PREADY is tied high, so every access phase completes at once
   assign access = apb_req.psel && apb_req.penable;
   assign wr_acc = access && apb_req.pwrite;
   assign rd_acc = access && !apb_req.pwrite;

   assign aligned  = apb_req.paddr[1:0] == 2'b00;
   assign word_idx = apb_req.paddr[BLK_SH-1:2];
   assign a_hit    = aligned && ((apb_req.paddr >> BLK_SH) == (`DOT_REG_A >> BLK_SH));
   assign b_hit    = aligned && ((apb_req.paddr >> BLK_SH) == (`DOT_REG_B >> BLK_SH));
   assign acc_hit  = apb_req.paddr == `DOT_REG_ACC;
   assign ctrl_hit = apb_req.paddr == `DOT_REG_CTRL;
   assign stat_hit = apb_req.paddr == `DOT_REG_STATUS;
   assign res_hit  = apb_req.paddr == `DOT_REG_RESULT;
   assign mapped   = a_hit || b_hit || acc_hit || ctrl_hit || stat_hit || res_hit;

   // --------------------
   // Side effects
   // --------------------

   // A start is only taken when the queue has room for its result
   assign start_req = wr_acc && ctrl_hit && apb_req.pwdata[0];
   assign start_ok  = start_req && credit_ok;

   // Reading RESULT pops the head entry at the end of the access phase
   assign pop       = rd_acc && res_hit && (count != 3'd0);
   assign clear_sat = wr_acc && stat_hit && apb_req.pwdata[8];

   always_ff @(posedge clk) begin
      if (rst) begin
         a_reg     <= '0;
         b_reg     <= '0;
         acc_reg   <= '0;
         job_valid <= 1'b0;
      end else begin
         job_valid <= start_ok;
         // Word k holds elements 4k to 4k+3, lowest element in the low byte
         if (wr_acc && a_hit) begin
            for (int j = 0; j < 4; j++) begin
               a_reg[4*word_idx+j] <= apb_req.pwdata[8*j +: 8];
            end
         end
         if (wr_acc && b_hit) begin
            for (int j = 0; j < 4; j++) begin
               b_reg[4*word_idx+j] <= apb_req.pwdata[8*j +: 8];
            end
         end
         if (wr_acc && acc_hit) begin
            acc_reg <= apb_req.pwdata[`DOT_ACC_W-1:0];
         end
      end
   end

   // The registers feed the datapath directly, it captures them on job_valid
   assign job = '{a: a_reg, b: b_reg, acc: acc_reg};

   // --------------------
   // Read data and errors
   // --------------------

   always_comb begin
      rd_word = '0;
      if (a_hit) begin
         for (int j = 0; j < 4; j++) begin
            rd_word[8*j +: 8] = a_reg[4*word_idx+j];
         end
      end else if (b_hit) begin
         for (int j = 0; j < 4; j++) begin
            rd_word[8*j +: 8] = b_reg[4*word_idx+j];
         end
      end else if (acc_hit) begin
         rd_word[`DOT_ACC_W-1:0] = acc_reg;
      end else if (stat_hit) begin
         // Sticky flag in bit 8, count in 3:1, result available in bit 0
         rd_word[8]   = sat_sticky;
         rd_word[3:1] = count;
         rd_word[0]   = count != 3'd0;
      end else if (res_hit) begin
         rd_word[`DOT_ACC_W]     = head.saturated;
         rd_word[`DOT_ACC_W-1:0] = head.value;
      end
   end

   // Empty RESULT reads, refused starts and unmapped addresses all fail
   assign err = !mapped || (rd_acc && res_hit && count == 3'd0) || (start_req && !credit_ok);

   assign apb_rsp = '{prdata: rd_word, pready: 1'b1, pslverr: access && err};

   // The queue count comes from result_queue, an empty pop would corrupt it
   a_no_empty_pop : assert property (@(posedge clk) disable iff (rst)
      pop |-> count != 3'd0);

endmodule

`default_nettype wire

/* src/result_queue.sv */
// Saturating result FIFO
`timescale 1ns/1ps
`default_nettype none

`include "dot_defs.svh"

module result_queue (
   input  logic                clk,
   input  logic                rst,
   input  dot_pkg::wide_sum_t  sum,
   input  logic                sum_valid,
   input  logic                pop,
   input  logic                clear_sat,
   input  logic                job_launch,
   output dot_pkg::result_t    head,
   output logic [2:0]          count,
   output logic                sat_sticky,
   output logic                credit_ok
);

   import dot_pkg::*;

   localparam int DEPTH = `DOT_Q_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);
   // Limits of a signed result
   localparam wide_sum_t SUM_MAX = 2**(`DOT_ACC_W-1) - 1;
   localparam wide_sum_t SUM_MIN = -(2**(`DOT_ACC_W-1));

   result_t          mem [DEPTH];
   result_t          entry;
   logic             over;
   logic             under;
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   // Jobs launched whose sums have not come back yet
   logic [2:0]       inflight;

   // --------------------
   // Saturation
   // --------------------

   assign over  = sum > SUM_MAX;
   assign under = sum < SUM_MIN;

   always_comb begin
      entry.saturated = over || under;
      if (over) begin
         entry.value = acc_t'(SUM_MAX);
      end else if (under) begin
         entry.value = acc_t'(SUM_MIN);
      end else begin
         entry.value = sum[`DOT_ACC_W-1:0];
      end
   end

   // --------------------
   // FIFO and credits
   // --------------------

   always_ff @(posedge clk) begin
      if (sum_valid) begin
         mem[wr_ptr] <= entry;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         inflight   <= '0;
         sat_sticky <= 1'b0;
      end else begin
         if (sum_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count    <= count + 3'(sum_valid) - 3'(pop);
         inflight <= inflight + 3'(job_launch) - 3'(sum_valid);
         // A new saturation wins over a clear in the same cycle
         if (sum_valid && entry.saturated) begin
            sat_sticky <= 1'b1;
         end else if (clear_sat) begin
            sat_sticky <= 1'b0;
         end
      end
   end

   assign head = mem[rd_ptr];

   // Stored plus pending results must leave room for one more job
   assign credit_ok = ({1'b0, count} + {1'b0, inflight}) < 4'(DEPTH);

   // The credit check in the register block keeps the FIFO from overflowing
   a_no_overflow : assert property (@(posedge clk) disable iff (rst)
      sum_valid |-> count != 3'(DEPTH));

endmodule

`default_nettype wire

/* src/dot_engine_top.sv */
// Dot-product engine top level
`timescale 1ns/1ps
`default_nettype none

module dot_engine_top (
   input  logic               clk,
   input  logic               rst,
   input  dot_pkg::apb_req_t  apb_req,
   output dot_pkg::apb_rsp_t  apb_rsp
);

   import dot_pkg::*;

   // Job handoff from the registers to the datapath
   dot_job_t   job;
   logic       job_valid;

   // Datapath output into the queue
   wide_sum_t  sum;
   logic       sum_valid;

   // Queue status back to the registers
   result_t    head;
   logic [2:0] count;
   logic       sat_sticky;
   logic       credit_ok;
   logic       pop;
   logic       clear_sat;

   // --------------------
   // Host side
   // --------------------

   apb_vector_regs regs_i (
      .clk        (clk),
      .rst        (rst),
      .apb_req    (apb_req),
      .apb_rsp    (apb_rsp),
      .job        (job),
      .job_valid  (job_valid),
      .head       (head),
      .count      (count),
      .sat_sticky (sat_sticky),
      .credit_ok  (credit_ok),
      .pop        (pop),
      .clear_sat  (clear_sat)
   );

   // --------------------
   // Datapath and queue
   // --------------------

   dot32_acc dot_i (
      .clk       (clk),
      .rst       (rst),
      .job       (job),
      .job_valid (job_valid),
      .sum       (sum),
      .sum_valid (sum_valid)
   );

   // The launch pulse feeds the in-flight count used for credits
   result_queue queue_i (
      .clk        (clk),
      .rst        (rst),
      .sum        (sum),
      .sum_valid  (sum_valid),
      .pop        (pop),
      .clear_sat  (clear_sat),
      .job_launch (job_valid),
      .head       (head),
      .count      (count),
      .sat_sticky (sat_sticky),
      .credit_ok  (credit_ok)
   );

endmodule

`default_nettype wire

/* verif/dot_engine_tb.sv */
// Dot-product engine testbench
`timescale 1ns/1ps
`default_nettype none

`include "dot_defs.svh"

module dot_engine_tb;

   import dot_pkg::*;

   localparam int WORDS     = `DOT_VEC_LEN / 4;
   localparam int MAX_POLLS = 30;

   logic     clk;
   logic     rst;
   apb_req_t apb_req;
   apb_rsp_t apb_rsp;

   // The a and b queues of the golden vectors hold WORDS entries per test
   string       g_name [$];
   logic [31:0] g_a [$];
   logic [31:0] g_b [$];
   logic [15:0] g_acc [$];
   logic [15:0] g_exp [$];
   logic        g_sat [$];
   logic        golden_bad = 1'b0;

   string cur_test;
   int    errors = 0;
   int    errs_at_start = 0;
   int    tests_passed = 0;
   int    tests_failed = 0;
   int    cycles = 0;
   int    cycle_limit = 0;
   // What the sticky STATUS flag should show right now
   logic  sticky_model = 1'b0;

   dot_engine_top dut_i (
      .clk     (clk),
      .rst     (rst),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Watchdog that ends a run going past the limit set from the golden file
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("Timeout: run still going after %0d cycles", cycles);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   // --------------------
   // Golden file
   // --------------------

   task automatic read_golden();
      int          fd;
      int          code;
      int          k;
      string       tok;
      string       rest;
      logic [31:0] word;
      fd = $fopen("verif/dot_engine_golden.txt", "r");
      if (fd == 0) begin
         golden_bad = 1'b1;
      end else begin
         while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tok);
            if (code == 1) begin
               if (tok.substr(0, 0) == "#") begin
                  code = $fgets(rest, fd);
               end else begin
                  g_name.push_back(tok);
                  for (k = 0; k < 2 * WORDS + 3; k++) begin
                     code = $fscanf(fd, "%h", word);
                     if (code != 1) golden_bad = 1'b1;
                     // The a words come first, then b words, acc, result and flag
                     if (k < WORDS) g_a.push_back(word);
                     else if (k < 2 * WORDS) g_b.push_back(word);
                     else if (k == 2 * WORDS) g_acc.push_back(word[15:0]);
                     else if (k == 2 * WORDS + 1) g_exp.push_back(word[15:0]);
                     else g_sat.push_back(word[0]);
                  end
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // --------------------
   // APB and checks
   // --------------------

   // One transfer after a random idle gap, with the response sampled mid access phase
   task automatic apb_xfer(input logic write, input logic [11:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata,
                           output logic err);
      int unsigned gap;
      gap = $urandom_range(2);
      repeat (gap) @(posedge clk);
      @(posedge clk);
      #1;
      apb_req.paddr   = addr;
      apb_req.pwrite  = write;
      apb_req.pwdata  = wdata;
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      @(posedge clk);
      #1;
      apb_req.penable = 1'b1;
      @(negedge clk);
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      expect_cond(apb_rsp.pready === 1'b1, "PREADY was low in the access phase");
      @(posedge clk);
      #1;
      apb_req.psel    = 1'b0;
      apb_req.penable = 1'b0;
   endtask

   task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                            output logic err);
      logic [31:0] unused;
      apb_xfer(1'b1, addr, data, unused, err);
   endtask

   task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                           output logic err);
      apb_xfer(1'b0, addr, 32'h0, data, err);
   endtask

   task automatic check_word(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
      assert (act === exp) else begin
         $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
         errors++;
      end
   endtask

   task automatic expect_cond(input logic cond, input string msg);
      assert (cond === 1'b1) else begin
         $display("Error in %s: %s", cur_test, msg);
         errors++;
      end
   endtask

   task automatic begin_test(input string name);
      cur_test      = name;
      errs_at_start = errors;
   endtask

   task automatic end_test();
      if (errors == errs_at_start) begin
         $display("Test %s: ok", cur_test);
         tests_passed++;
      end else begin
         $display("Test %s: %0d error(s)", cur_test, errors - errs_at_start);
         tests_failed++;
      end
   endtask

   // --------------------
   // Job helpers
   // --------------------

   task automatic load_job(input int idx);
      logic err;
      for (int k = 0; k < WORDS; k++) begin
         apb_write(12'(`DOT_REG_A + 4 * k), g_a[idx * WORDS + k], err);
         expect_cond(!err, "write to the a vector raised pslverr");
         apb_write(12'(`DOT_REG_B + 4 * k), g_b[idx * WORDS + k], err);
         expect_cond(!err, "write to the b vector raised pslverr");
      end
      apb_write(`DOT_REG_ACC, {16'h0, g_acc[idx]}, err);
      expect_cond(!err, "write to ACC raised pslverr");
   endtask

   task automatic start_job();
      logic err;
      apb_write(`DOT_REG_CTRL, 32'h1, err);
      expect_cond(!err, "job start was refused with pslverr");
   endtask

   // Polls STATUS until the queue holds n results
   task automatic wait_count(input int n);
      logic [31:0] st;
      logic        err;
      logic        seen;
      int          tries;
      seen  = 1'b0;
      tries = 0;
      while (!seen && tries < MAX_POLLS) begin
         apb_read(`DOT_REG_STATUS, st, err);
         tries++;
         if (st[3:1] == 3'(n)) seen = 1'b1;
      end
      expect_cond(seen, $sformatf("STATUS never showed %0d results", n));
      expect_cond(st[0] == (n != 0), "result-available bit disagrees with the count");
   endtask

   task automatic check_status();
      logic [31:0] st;
      logic        err;
      apb_read(`DOT_REG_STATUS, st, err);
      expect_cond(!err, "STATUS read raised pslverr");
      check_word("status", {23'h0, sticky_model, 8'h00}, st);
   endtask

   task automatic clear_sticky();
      logic err;
      apb_write(`DOT_REG_STATUS, 32'h100, err);
      expect_cond(!err, "clearing the sticky flag raised pslverr");
      sticky_model = 1'b0;
      check_status();
   endtask

   // --------------------
   // Tests
   // --------------------

   task automatic reset_state_test();
      logic [31:0] rd;
      logic        err;
      begin_test("reset_state");
      apb_read(`DOT_REG_STATUS, rd, err);
      expect_cond(!err, "STATUS read after reset raised pslverr");
      check_word("status", 32'h0, rd);
      apb_read(`DOT_REG_RESULT, rd, err);
      expect_cond(err, "reading RESULT from an empty queue gave no pslverr");
      apb_read(12'h100, rd, err);
      expect_cond(err, "an unmapped address gave no pslverr");
      end_test();
   endtask

   task automatic readback_test();
      logic [31:0] a_w [WORDS];
      logic [31:0] b_w [WORDS];
      logic [31:0] acc_w;
      logic [31:0] rd;
      logic        err;
      begin_test("register_readback");
      for (int k = 0; k < WORDS; k++) begin
         a_w[k] = $urandom();
         b_w[k] = $urandom();
         apb_write(12'(`DOT_REG_A + 4 * k), a_w[k], err);
         apb_write(12'(`DOT_REG_B + 4 * k), b_w[k], err);
      end
      acc_w = $urandom();
      apb_write(`DOT_REG_ACC, acc_w, err);
      for (int k = 0; k < WORDS; k++) begin
         apb_read(12'(`DOT_REG_A + 4 * k), rd, err);
         check_word($sformatf("a word %0d", k), a_w[k], rd);
         apb_read(12'(`DOT_REG_B + 4 * k), rd, err);
         check_word($sformatf("b word %0d", k), b_w[k], rd);
      end
      // Only the low half of ACC is stored
      apb_read(`DOT_REG_ACC, rd, err);
      check_word("acc", {16'h0, acc_w[15:0]}, rd);
      end_test();
   endtask

   // A flag set in an earlier test must still be there, then gets cleared
   task automatic run_golden(input int idx);
      logic [31:0] rd;
      logic        err;
      logic        prev;
      begin_test(g_name[idx]);
      prev = sticky_model;
      load_job(idx);
      start_job();
      wait_count(1);
      apb_read(`DOT_REG_RESULT, rd, err);
      expect_cond(!err, "RESULT read raised pslverr with a result queued");
      check_word("result", {15'h0, g_sat[idx], g_exp[idx]}, rd);
      sticky_model = sticky_model | g_sat[idx];
      check_status();
      if (prev) clear_sticky();
      end_test();
   endtask

   task automatic burst_test();
      logic [31:0] rd;
      logic        err;
      begin_test("burst_of_four");
      for (int k = 0; k < 4; k++) begin
         load_job(k);
         start_job();
      end
      // Four results stored or in flight, so no credit is left
      apb_write(`DOT_REG_CTRL, 32'h1, err);
      expect_cond(err, "a fifth start was accepted without credit");
      wait_count(4);
      for (int k = 0; k < 4; k++) begin
         apb_read(`DOT_REG_RESULT, rd, err);
         expect_cond(!err, "RESULT read raised pslverr with results queued");
         check_word($sformatf("result %0d", k), {15'h0, g_sat[k], g_exp[k]}, rd);
         sticky_model = sticky_model | g_sat[k];
      end
      check_status();
      clear_sticky();
      end_test();
   endtask

   initial begin
      int unsigned seed_val;
      seed_val = $urandom(4939);
      rst      = 1'b1;
      apb_req  = '0;
      read_golden();
      if (golden_bad || g_name.size() < 4) begin
         $display("Golden file is missing, malformed or holds fewer than four tests");
         $display("*** TEST FAILED ***");
         $finish;
      end else begin
         cycle_limit = (g_name.size() + 3) * 200;
         repeat (5) @(posedge clk);
         #1;
         rst = 1'b0;
         reset_state_test();
         readback_test();
         for (int i = 0; i < g_name.size(); i++) begin
            run_golden(i);
         end
         burst_test();
         $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
         if (tests_failed == 0 && errors == 0) begin
            $display("*** TEST PASSED ***");
         end else begin
            $display("*** TEST FAILED ***");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

/* verif/dot_engine_golden.txt */
# Columns: name, a words 0-7, b words 0-7, acc, expected result, expected saturation flag
# All numbers are hex; word k holds elements 4k to 4k+3 with the lowest element in the low byte
zeros 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0000 0000 0
ones 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 0000 0020 0
acc_only 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 1234 1234 0
neg_acc 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 02020202 02020202 02020202 02020202 02020202 02020202 02020202 02020202 FF00 FF40 0
neg_elems FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF 03030303 03030303 03030303 03030303 03030303 03030303 03030303 03030303 0000 FFA0 0
sat_low 7F7F7F7F 7F7F7F7F 7F7F7F7F 7F7F7F7F 7F7F7F7F 7F7F7F7F 7F7F7F7F 7F7F7F7F 81818181 81818181 81818181 81818181 81818181 81818181 81818181 81818181 0000 8000 1
sat_high 80808080 80808080 80808080 80808080 80808080 80808080 80808080 80808080 80808080 80808080 80808080 80808080 80808080 80808080 80808080 80808080 7FFF 7FFF 1
edge_max 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 7FDF 7FFF 0
edge_over 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 7FE0 7FFF 1
edge_min FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 8020 8000 0
edge_under FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 801F 8000 1
halves_cancel 02020202 02020202 02020202 02020202 FEFEFEFE FEFEFEFE FEFEFEFE FEFEFEFE 05050505 05050505 05050505 05050505 05050505 05050505 05050505 05050505 0007 0007 0
lower_only 10101010 10101010 10101010 10101010 00000000 00000000 00000000 00000000 08080808 08080808 08080808 08080808 00000000 00000000 00000000 00000000 0000 0800 0
upper_only 00000000 00000000 00000000 00000000 F0F0F0F0 F0F0F0F0 F0F0F0F0 F0F0F0F0 00000000 00000000 00000000 00000000 08080808 08080808 08080808 08080808 0100 F900 0
mixed_lanes 0102FF80 0102FF80 0102FF80 0102FF80 0102FF80 0102FF80 0102FF80 0102FF80 01010101 01010101 01010101 01010101 01010101 01010101 01010101 01010101 0000 FC10 0
mixed_both 0102FF80 0102FF80 0102FF80 0102FF80 0102FF80 0102FF80 0102FF80 0102FF80 80FF0201 80FF0201 80FF0201 80FF0201 80FF0201 80FF0201 80FF0201 80FF0201 0820 0000 0
big_pos 64646464 64646464 64646464 64646464 64646464 64646464 64646464 64646464 0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A 0000 7D00 0
big_pos_neg_acc 64646464 64646464 64646464 64646464 64646464 64646464 64646464 64646464 0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A 8000 FD00 0
sat_low_acc 80808080 80808080 80808080 80808080 80808080 80808080 80808080 80808080 7F7F7F7F 7F7F7F7F 7F7F7F7F 7F7F7F7F 7F7F7F7F 7F7F7F7F 7F7F7F7F 7F7F7F7F 7FFF 8000 1
end_elems 00000005 00000000 00000000 00000000 00000000 00000000 00000000 0A000000 00000007 00000000 00000000 00000000 00000000 00000000 00000000 F5000000 0000 FFB5 0

/* build.f */
+incdir+include
src/dot_pkg.sv
src/dot16_tree.sv
src/dot32_acc.sv
src/apb_vector_regs.sv
src/result_queue.sv
src/dot_engine_top.sv
verif/dot_engine_tb.sv
